// File: Bender.yml
package:
  name: stereo_sad

# design top: stereo_sad_top
# testbench top: stereo_sad_tb
sources:
  - files:
      - stereo_pixel_pkg.sv
      - stereo_ctrl_pkg.sv
      - sad_pipe_delay.sv
      - sad_absdiff.sv
      - sad_accumulator_slice.sv
      - sad_accumulator.sv
      - stereo_sad_top.sv
  - target: test
    files:
      - stereo_sad_assertions.sv
      - stereo_sad_tb.sv

// File: sad_absdiff.sv
`timescale 1ns/1ps

module sad_absdiff (
    input  logic                          clk,
    input  logic                          rst,
    input  stereo_pixel_pkg::pixel_beat_t pix,
    output stereo_pixel_pkg::cost_beat_t  cost
);

    localparam int NUM_DISP = stereo_pixel_pkg::NUM_DISP;

    always_ff @(posedge clk) begin
        cost.first <= pix.first;

        // absolute difference per disparity by subtracting the smaller pixel
        for (int d = 0; d < NUM_DISP; d++) begin
            if (pix.left > pix.right[d]) begin
                cost.cost[d] <= pix.left - pix.right[d];
            end else begin
                cost.cost[d] <= pix.right[d] - pix.left;
            end
        end

        if (rst) begin
            cost.valid <= 1'b0;
        end else begin
            cost.valid <= pix.valid;
        end
    end

endmodule

// File: sad_accumulator.sv
`timescale 1ns/1ps

module sad_accumulator #(
    parameter int WINDOW = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  stereo_pixel_pkg::cost_beat_t  cost,
    output stereo_pixel_pkg::sad_result_t result
);

    localparam int NUM_DISP = stereo_pixel_pkg::NUM_DISP;
    localparam int SUM_W    = stereo_pixel_pkg::SUM_BITS;
    localparam int CNT_BITS = stereo_ctrl_pkg::fill_count_bits(WINDOW);
    // counter value on the beat before the window completes
    localparam logic [CNT_BITS-1:0] FILL_LAST = CNT_BITS'((WINDOW > 1) ? WINDOW - 2 : 0);

    stereo_ctrl_pkg::window_phase_e phase;
    logic [CNT_BITS-1:0]             fill_cnt;
    logic                            run_open;
    logic                            c1_valid;
    logic                            c1_out_en;
    logic                            c1_shift_out;
    logic                            c2_first;
    logic                            c2_out_valid;
    logic                            c3_out_valid;
    logic                            c4_out_valid;
    logic [NUM_DISP-1:0][SUM_W-1:0]  c4_sum;

    // phase after each valid beat, bubbles leave it alone
    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= stereo_ctrl_pkg::PH_FILL;
            fill_cnt <= '0;
            run_open <= 1'b0;
        end else if (cost.valid) begin
            if (cost.first) begin
                run_open <= 1'b1;
                fill_cnt <= '0;
                phase    <= (WINDOW == 1) ? stereo_ctrl_pkg::PH_FULL
                                          : stereo_ctrl_pkg::PH_FILL;
            end else if (run_open) begin
                case (phase)
                    stereo_ctrl_pkg::PH_FILL: begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == FILL_LAST) begin
                            phase <= stereo_ctrl_pkg::PH_FULL;
                        end
                    end
                    stereo_ctrl_pkg::PH_FULL:  phase <= stereo_ctrl_pkg::PH_SLIDE;
                    stereo_ctrl_pkg::PH_SLIDE: phase <= stereo_ctrl_pkg::PH_SLIDE;
                    default:                   phase <= stereo_ctrl_pkg::PH_FILL;
                endcase
            end
        end
    end

    assign c1_out_en    = (phase != stereo_ctrl_pkg::PH_FILL);
    assign c1_shift_out = (phase == stereo_ctrl_pkg::PH_SLIDE);

    // output enable rides alongside the slice sums
    always_ff @(posedge clk) begin
        if (rst) begin
            c1_valid     <= 1'b0;
            c2_out_valid <= 1'b0;
            c3_out_valid <= 1'b0;
            c4_out_valid <= 1'b0;
        end else begin
            c1_valid     <= cost.valid;
            c2_out_valid <= c1_valid && c1_out_en;
            c3_out_valid <= c2_out_valid;
            c4_out_valid <= c3_out_valid;
        end
    end

    sad_pipe_delay #(
        .WIDTH    (1),
        .DELAY    (2)
    ) sad_pipe_delay_first_inst (
        .clk      (clk),
        .in_data  (cost.first),
        .out_data (c2_first)
    );

    for (genvar j = 0; j < NUM_DISP; j++) begin : gen_slices
        sad_accumulator_slice #(
            .WINDOW       (WINDOW)
        ) sad_accumulator_slice_inst (
            .clk          (clk),
            .rst          (rst),
            .c0_cost      (cost.cost[j]),
            .c1_valid     (c1_valid),
            .c1_shift_out (c1_shift_out),
            .c2_first     (c2_first),
            .c4_sum       (c4_sum[j])
        );
    end

    assign result = '{valid: c4_out_valid, sum: c4_sum};

endmodule

// File: sad_accumulator_slice.sv
`timescale 1ns/1ps

module sad_accumulator_slice #(
    parameter int WINDOW = 5
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [stereo_pixel_pkg::PIXEL_BITS-1:0] c0_cost,
    input  logic                                c1_valid,
    input  logic                                c1_shift_out,
    input  logic                                c2_first,
    output logic [stereo_pixel_pkg::SUM_BITS-1:0]   c4_sum
);

    localparam int PIX_W = stereo_pixel_pkg::PIXEL_BITS;
    localparam int SUM_W = stereo_pixel_pkg::SUM_BITS;

    logic [PIX_W-1:0] c1_cost;
    logic [PIX_W-1:0] hist [WINDOW];
    logic [PIX_W-1:0] c2_add;
    logic [PIX_W-1:0] c2_sub;
    logic             c2_valid;
    logic [SUM_W-1:0] c2_diff;
    logic [SUM_W-1:0] c3_sum;

    // align cost with the shared c1 controls
    always_ff @(posedge clk) begin
        c1_cost <= c0_cost;
    end

    // cost history, moves only on valid beats
    always_ff @(posedge clk) begin
        if (c1_valid) begin
            hist[0] <= c1_cost;
            for (int i = 1; i < WINDOW; i++) begin
                hist[i] <= hist[i-1];
            end
            c2_add <= c1_cost;
            // oldest entry only counts once the window has slid
            c2_sub <= c1_shift_out ? hist[WINDOW-1] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            c2_valid <= 1'b0;
        end else begin
            c2_valid <= c1_valid;
        end
    end

    // running sum never goes negative, so modular subtract is exact
    assign c2_diff = SUM_W'(c2_add) - SUM_W'(c2_sub);

    always_ff @(posedge clk) begin
        if (c2_valid) begin
            if (c2_first) begin
                c3_sum <= SUM_W'(c2_add);
            end else begin
                c3_sum <= c3_sum + c2_diff;
            end
        end
    end

    always_ff @(posedge clk) begin
        c4_sum <= c3_sum;
    end

endmodule

// File: sad_pipe_delay.sv
`timescale 1ns/1ps

module sad_pipe_delay #(
    parameter int WIDTH = 1,
    parameter int DELAY = 2
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    // one register per cycle of delay
    logic [WIDTH-1:0] stage [DELAY];

    always_ff @(posedge clk) begin
        stage[0] <= in_data;
        for (int i = 1; i < DELAY; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    assign out_data = stage[DELAY-1];

endmodule

// File: stereo_ctrl_pkg.sv
package stereo_ctrl_pkg;

    // phase of the sliding window after the latest valid beat
    typedef enum logic [1:0] {
        // still filling, output masked
        PH_FILL  = 2'd0,
        // window just completed, no subtraction yet
        PH_FULL  = 2'd1,
        // oldest cost drops out on every beat
        PH_SLIDE = 2'd2
    } window_phase_e;

    // fill counter width for a given window length
    function automatic int fill_count_bits(input int window);
        int bits;
        bits = $clog2(window);
        if (bits < 1) begin
            bits = 1;
        end
        return bits;
    endfunction

endpackage

// File: stereo_pixel_pkg.sv
package stereo_pixel_pkg;

    // pixel and cost width
    localparam int PIXEL_BITS = 8;

    // candidate disparities carried in one beat
    localparam int NUM_DISP = 4;

    // window sum width, enough for 255 * 257
    localparam int SUM_BITS = 16;

    typedef struct packed {
        logic                                  valid;
        logic                                  first;
        logic [PIXEL_BITS-1:0]                 left;
        logic [NUM_DISP-1:0][PIXEL_BITS-1:0]   right;
    } pixel_beat_t;

    typedef struct packed {
        logic                                  valid;
        logic                                  first;
        logic [NUM_DISP-1:0][PIXEL_BITS-1:0]   cost;
    } cost_beat_t;

    typedef struct packed {
        logic                                  valid;
        logic [NUM_DISP-1:0][SUM_BITS-1:0]     sum;
    } sad_result_t;

endpackage

// File: stereo_sad.f
stereo_pixel_pkg.sv
stereo_ctrl_pkg.sv
sad_pipe_delay.sv
sad_absdiff.sv
sad_accumulator_slice.sv
sad_accumulator.sv
stereo_sad_top.sv
stereo_sad_assertions.sv
stereo_sad_tb.sv

// File: stereo_sad_assertions.sv
`timescale 1ns/1ps

module stereo_sad_assertions #(
    parameter int WINDOW = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  stereo_pixel_pkg::pixel_beat_t pix,
    input  stereo_pixel_pkg::sad_result_t result
);

    localparam int CNT_W   = stereo_ctrl_pkg::fill_count_bits(WINDOW) + 1;
    localparam int MAX_SUM = ((1 << stereo_pixel_pkg::PIXEL_BITS) - 1) * WINDOW;
    // input beat to result beat
    localparam int LATENCY = 5;

    logic [CNT_W-1:0] run_beats;
    logic             in_run;
    logic             beat_masked;
    int               assert_failures = 0;

    // valid beats seen in the open run, saturates at WINDOW
    always_ff @(posedge clk) begin
        if (rst) begin
            in_run    <= 1'b0;
            run_beats <= '0;
        end else if (pix.valid) begin
            if (pix.first) begin
                in_run    <= 1'b1;
                run_beats <= CNT_W'(1);
            end else if (in_run && int'(run_beats) < WINDOW) begin
                run_beats <= run_beats + 1'b1;
            end
        end
    end

    // beat that cannot close a full window
    always_comb begin
        beat_masked = 1'b0;
        if (pix.valid) begin
            if (pix.first) begin
                beat_masked = (WINDOW > 1);
            end else begin
                beat_masked = !in_run || (int'(run_beats) + 1 < WINDOW);
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) rst |=> !result.valid)
        else begin
            $error("result valid during or right after reset");
            assert_failures++;
        end

    bubble_silent: assert property (@(posedge clk) disable iff (rst)
        !$past(pix.valid, LATENCY) |-> !result.valid)
        else begin
            $error("result valid for an input bubble");
            assert_failures++;
        end

    masked_silent: assert property (@(posedge clk) disable iff (rst)
        $past(beat_masked, LATENCY) |-> !result.valid)
        else begin
            $error("result valid before the window was full");
            assert_failures++;
        end

    for (genvar d = 0; d < stereo_pixel_pkg::NUM_DISP; d++) begin : gen_sum_range
        sum_in_range: assert property (@(posedge clk) disable iff (rst)
            result.valid |-> (int'(result.sum[d]) <= MAX_SUM))
            else begin
                $error("window sum of disparity %0d above full scale", d);
                assert_failures++;
            end
    end

endmodule

bind stereo_sad_top stereo_sad_assertions #(
    .WINDOW (WINDOW)
) stereo_sad_assertions_inst (
    .clk    (clk),
    .rst    (rst),
    .pix    (pix),
    .result (result)
);

// File: stereo_sad_tb.sv
`timescale 1ns/1ps

module stereo_sad_tb;

    localparam int WINDOW       = 5;
    localparam int NUM_DISP     = stereo_pixel_pkg::NUM_DISP;
    localparam int PIX_W        = stereo_pixel_pkg::PIXEL_BITS;
    localparam int SUM_W        = stereo_pixel_pkg::SUM_BITS;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 3;
    localparam int DRAIN_CYCLES = 8;
    // tokens per line of the vector file
    localparam int COLS         = 12;
    localparam int MAX_VECS     = 128;

    typedef logic [NUM_DISP-1:0][SUM_W-1:0] sum_vec_t;

    logic                          clk;
    logic                          rst;
    stereo_pixel_pkg::pixel_beat_t pix;
    stereo_pixel_pkg::sad_result_t result;

    logic [15:0] vec_mem [MAX_VECS*COLS];
    int          num_vecs;
    logic        vectors_loaded;
    sum_vec_t    expected_q [$];
    string       name_q [$];
    int          run_idx;
    int          beat_idx;
    int          checked_count;
    int          mismatch_count;
    int          unexpected_count;
    int          missing_count;
    int          other_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    stereo_sad_top #(
        .WINDOW (WINDOW)
    ) stereo_sad_top_inst (
        .clk    (clk),
        .rst    (rst),
        .pix    (pix),
        .result (result)
    );

    // lines end where the valid column was never written
    task automatic count_vectors();
        num_vecs = 0;
        while (num_vecs < MAX_VECS && !$isunknown(vec_mem[num_vecs * COLS])) begin
            assert (!$isunknown(vec_mem[num_vecs * COLS + COLS - 1])) else begin
                $display("vector line %0d is incomplete", num_vecs);
                other_count++;
            end
            num_vecs++;
        end
    endtask

    task automatic apply_line(input int line);
        int       base;
        sum_vec_t expected;
        base = line * COLS;
        pix.valid = vec_mem[base][0];
        pix.first = vec_mem[base + 1][0];
        pix.left  = vec_mem[base + 2][PIX_W-1:0];
        for (int d = 0; d < NUM_DISP; d++) begin
            pix.right[d] = vec_mem[base + 3 + d][PIX_W-1:0];
        end
        // beat numbering within the run, first beat is 1
        if (pix.valid && pix.first) begin
            run_idx++;
            beat_idx = 0;
        end
        if (pix.valid) begin
            beat_idx++;
        end
        if (vec_mem[base + 7][0]) begin
            for (int d = 0; d < NUM_DISP; d++) begin
                expected[d] = vec_mem[base + 8 + d][SUM_W-1:0];
            end
            expected_q.push_back(expected);
            name_q.push_back($sformatf("run%0d_beat%0d", run_idx, beat_idx));
        end
    endtask

    task automatic check_output();
        sum_vec_t expected;
        string    name;
        assert (expected_q.size() > 0) else begin
            $display("an output beat appeared while no result was expected");
            unexpected_count++;
        end
        if (expected_q.size() > 0) begin
            expected = expected_q.pop_front();
            name = name_q.pop_front();
            checked_count++;
            for (int d = 0; d < NUM_DISP; d++) begin
                assert (result.sum[d] === expected[d]) else begin
                    $display("error: %s disparity %0d expected %0d actual %0d",
                             name, d, expected[d], result.sum[d]);
                    mismatch_count++;
                end
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (!$isunknown(result.valid)) else begin
                $display("output valid is unknown after reset");
                other_count++;
            end
            if (result.valid === 1'b1) begin
                check_output();
            end
        end
    end

    initial begin : watchdog
        wait (vectors_loaded);
        #((num_vecs + 20) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", num_vecs + 20);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        int assert_errors;
        clk              = 1'b0;
        rst              = 1'b1;
        pix              = '0;
        vectors_loaded   = 1'b0;
        run_idx          = 0;
        beat_idx         = 0;
        checked_count    = 0;
        mismatch_count   = 0;
        unexpected_count = 0;
        missing_count    = 0;
        other_count      = 0;
        for (int i = 0; i < MAX_VECS * COLS; i++) begin
            vec_mem[i] = 'x;
        end
        $readmemh("stereo_sad_vectors.txt", vec_mem);
        count_vectors();
        assert (num_vecs > 0) else begin
            $display("no stimulus lines found in the vector file");
            other_count++;
        end
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int i = 0; i < num_vecs; i++) begin
            apply_line(i);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        pix = '0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);

        missing_count = expected_q.size();
        assert (missing_count == 0) else begin
            $display("%0d expected output beats never appeared", missing_count);
        end
        assert_errors = stereo_sad_top_inst.stereo_sad_assertions_inst.assert_failures;
        $display("checked %0d, mismatches %0d, unexpected %0d, missing %0d, other %0d, assertions %0d",
                 checked_count, mismatch_count, unexpected_count, missing_count,
                 other_count, assert_errors);
        if (mismatch_count + unexpected_count + missing_count + other_count
                + assert_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: stereo_sad_top.sv
`timescale 1ns/1ps

module stereo_sad_top #(
    parameter int WINDOW = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  stereo_pixel_pkg::pixel_beat_t pix,
    output stereo_pixel_pkg::sad_result_t result
);

    // per-disparity costs, one cycle behind pix
    stereo_pixel_pkg::cost_beat_t cost;

    sad_absdiff sad_absdiff_inst (
        .clk    (clk),
        .rst    (rst),
        .pix    (pix),
        .cost   (cost)
    );

    // window sums appear four cycles after the cost beat
    sad_accumulator #(
        .WINDOW (WINDOW)
    ) sad_accumulator_inst (
        .clk    (clk),
        .rst    (rst),
        .cost   (cost),
        .result (result)
    );

endmodule

// File: stereo_sad_vectors.txt
// columns: valid first left right0 right1 right2 right3 exp_valid sum0 sum1 sum2 sum3
// all hex; sums are checked only when exp_valid is 1, window length 5
// beats before any first, no output
1 0 0a 14 1e 28 32 0 0000 0000 0000 0000
1 0 64 5a 50 46 3c 0 0000 0000 0000 0000
0 0 00 00 00 00 00 0 0000 0000 0000 0000
// run 1, left above and below right, window closes on beat 5
1 1 32 28 3c 2d 46 0 0000 0000 0000 0000
1 0 78 64 82 78 5a 0 0000 0000 0000 0000
1 0 1e 21 19 3c 00 0 0000 0000 0000 0000
1 0 c8 d2 be 96 ff 0 0000 0000 0000 0000
1 0 4d 46 50 4d 64 1 0032 0026 0055 009e
1 0 05 00 0f 05 09 1 002d 0026 0050 008e
// bubbles inside the run, their pixels and first bit are ignored
0 0 ff 00 00 00 00 0 0000 0000 0000 0000
0 1 00 ff ff ff ff 0 0000 0000 0000 0000
1 0 3c 40 32 3c 64 1 001d 0026 0050 0098
1 0 8c 80 96 64 8d 1 0026 002b 005a 007b
// run 2 restarts in the middle, one bubble while filling
1 1 5a 64 50 5f 5a 0 0000 0000 0000 0000
1 0 0a 00 1e 0a 0c 0 0000 0000 0000 0000
1 0 2c 28 32 2c 22 0 0000 0000 0000 0000
0 0 00 00 00 00 00 0 0000 0000 0000 0000
1 0 b4 c8 aa b4 b5 0 0000 0000 0000 0000
1 0 42 3c 46 42 00 1 0032 0032 0005 004f
1 0 01 02 00 01 0b 1 0029 0029 0000 0059
// run 3, full-scale costs reach 1275
1 1 00 ff ff 00 ff 0 0000 0000 0000 0000
1 0 ff 00 00 ff 00 0 0000 0000 0000 0000
1 0 00 ff ff 00 ff 0 0000 0000 0000 0000
1 0 ff 00 00 ff 00 0 0000 0000 0000 0000
1 0 00 ff ff 00 ff 1 04fb 04fb 0000 04fb
1 0 ff 00 00 ff 00 1 04fb 04fb 0000 04fb
1 0 00 ff 80 ff ff 1 04fb 047c 00ff 04fb
1 0 ff 00 ff 00 00 1 04fb 037d 01fe 04fb
// run 4 never fills
1 1 09 09 09 09 09 0 0000 0000 0000 0000
1 0 12 09 09 09 09 0 0000 0000 0000 0000
1 0 12 09 09 09 09 0 0000 0000 0000 0000
0 0 00 00 00 00 00 0 0000 0000 0000 0000
0 0 00 00 00 00 00 0 0000 0000 0000 0000
